/* compile.f */
+incdir+design
design/exec_pkg.sv
design/alu.sv
design/branch_unit.sv
design/mem_request.sv
design/writeback_stage.sv
design/exec_stage.sv
verification/exec_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps -f compile.f --top-module exec_stage_tb -o exec_stage_sim

output="$(./obj_dir/exec_stage_sim)" || true
echo "$output"

if grep -qxF -- "** PASS **" <<< "$output"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* verification/exec_stage_tb.sv */
// Self-checking testbench for the execute stage
// Inputs come from an LFSR and expected values from a reference model
// Registered outputs are checked one non-stalled edge later
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module exec_stage_tb;

    localparam int HALF_PERIOD = 20;

    logic                   clk;
    logic                   reset_n;
    logic                   stall;
    exec_pkg::op_e          operation;
    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       second_operand;
    logic [`XLEN-1:0]       jump_imm_target;
    logic [`REG_ADDR_W-1:0] rd;
    logic                   compressed;

    logic [`XLEN-1:0]       mem_address_o;
    logic                   mem_read_enable_o;
    logic [`BE_W-1:0]       mem_write_enable_o;
    logic [`XLEN-1:0]       mem_write_data_o;
    logic                   jump_o;
    logic [`XLEN-1:0]       jump_target_o;
    logic [`XLEN-1:0]       result_o;
    logic [`XLEN-1:0]       result_fwd_o;
    logic [`REG_ADDR_W-1:0] rd_o;
    logic                   write_enable_o;
    logic                   write_enable_fwd_o;
    exec_pkg::op_e          operation_o;

    logic [31:0]            lfsr_state;
    int                     checks_done;

    // Register contents expected after the last edge
    logic [`XLEN-1:0]       exp_result;
    logic [`REG_ADDR_W-1:0] exp_rd;
    logic                   exp_we;
    exec_pkg::op_e          exp_op;

    exec_stage exec_stage_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall              (stall),
        .operation_i        (operation),
        .pc_i               (pc),
        .rs1_data_i         (rs1_data),
        .rs2_data_i         (rs2_data),
        .second_operand_i   (second_operand),
        .jump_imm_target_i  (jump_imm_target),
        .rd_i               (rd),
        .compressed_i       (compressed),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o),
        .jump_o             (jump_o),
        .jump_target_o      (jump_target_o),
        .result_o           (result_o),
        .result_fwd_o       (result_fwd_o),
        .rd_o               (rd_o),
        .write_enable_o     (write_enable_o),
        .write_enable_fwd_o (write_enable_fwd_o),
        .operation_o        (operation_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    ////////////////////////////////////////////////
    // Random source
    ////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////

    function automatic void reference_model(
        input  exec_pkg::op_e          op,
        input  logic [`XLEN-1:0]       pc_v,
        input  logic [`XLEN-1:0]       rs1,
        input  logic [`XLEN-1:0]       rs2,
        input  logic [`XLEN-1:0]       opb,
        input  logic [`XLEN-1:0]       jimm,
        input  logic [`REG_ADDR_W-1:0] rd_v,
        input  logic                   comp,
        output logic [`XLEN-1:0]       result,
        output logic                   we,
        output logic                   jump,
        output logic [`XLEN-1:0]       target,
        output logic [`XLEN-1:0]       addr,
        output logic                   rd_en,
        output logic [`BE_W-1:0]       wr_en,
        output logic [`XLEN-1:0]       wr_data
    );
        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] link;
        sum     = rs1 + opb;
        link    = pc_v + (comp ? `XLEN'(`LINK_STEP_COMPRESSED) : `XLEN'(`LINK_STEP_FULL));
        result  = sum;
        we      = (op != exec_pkg::NOP) && (rd_v != '0);
        jump    = 1'b0;
        target  = jimm;
        addr    = {sum[`XLEN-1:2], 2'b00};
        rd_en   = 1'b0;
        wr_en   = '0;
        wr_data = rs2;
        case (op)
            exec_pkg::SUB:    result = rs1 - opb;
            exec_pkg::AND_OP: result = rs1 & opb;
            exec_pkg::OR_OP:  result = rs1 | opb;
            exec_pkg::XOR_OP: result = rs1 ^ opb;
            exec_pkg::SLL:    result = rs1 << opb[4:0];
            exec_pkg::SRL:    result = rs1 >> opb[4:0];
            exec_pkg::SRA:    result = `XLEN'($signed(rs1) >>> opb[4:0]);
            exec_pkg::SLT:    result = `XLEN'($signed(rs1) < $signed(opb));
            exec_pkg::SLTU:   result = `XLEN'(rs1 < opb);
            exec_pkg::LUI:    result = opb;
            exec_pkg::AUIPC:  result = jimm;
            exec_pkg::JAL: begin
                result = link;
                jump   = 1'b1;
            end
            exec_pkg::JALR: begin
                result = link;
                jump   = 1'b1;
                target = {sum[`XLEN-1:1], 1'b0};
            end
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::BLT,
            exec_pkg::BLTU, exec_pkg::BGE, exec_pkg::BGEU: begin
                we = 1'b0;
                case (op)
                    exec_pkg::BEQ:  jump = rs1 == opb;
                    exec_pkg::BNE:  jump = rs1 != opb;
                    exec_pkg::BLT:  jump = $signed(rs1) < $signed(opb);
                    exec_pkg::BLTU: jump = rs1 < opb;
                    exec_pkg::BGE:  jump = $signed(rs1) >= $signed(opb);
                    default:        jump = rs1 >= opb;
                endcase
            end
            exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH,
            exec_pkg::LHU, exec_pkg::LW: rd_en = 1'b1;
            exec_pkg::SB: begin
                we      = 1'b0;
                wr_en   = 4'b0001 << sum[1:0];
                wr_data = {4{rs2[7:0]}};
            end
            exec_pkg::SH: begin
                we      = 1'b0;
                wr_en   = sum[1] ? 4'b1100 : 4'b0011;
                wr_data = {2{rs2[15:0]}};
            end
            exec_pkg::SW: begin
                we    = 1'b0;
                wr_en = 4'b1111;
            end
            default: begin
            end
        endcase
    endfunction

    ////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s during %s, got %h, expected %h",
                     $time, what, operation.name(), actual, expected);
            stop_on_failure();
        end
    endtask

    task automatic compare_outputs();
        logic [`XLEN-1:0] result;
        logic             we;
        logic             jump;
        logic [`XLEN-1:0] target;
        logic [`XLEN-1:0] addr;
        logic             rd_en;
        logic [`BE_W-1:0] wr_en;
        logic [`XLEN-1:0] wr_data;
        // Registered side loaded at the last edge
        check_value(result_o, exp_result, "result_o");
        check_value(`XLEN'(rd_o), `XLEN'(exp_rd), "rd_o");
        check_value(`XLEN'(write_enable_o), `XLEN'(exp_we), "write_enable_o");
        check_value(`XLEN'(operation_o), `XLEN'(exp_op), "operation_o");
        reference_model(operation, pc, rs1_data, rs2_data, second_operand, jump_imm_target,
                        rd, compressed, result, we, jump, target, addr, rd_en, wr_en, wr_data);
        // Combinational side follows the present inputs even while stalled
        check_value(result_fwd_o, result, "result_fwd_o");
        check_value(`XLEN'(write_enable_fwd_o), `XLEN'(we), "write_enable_fwd_o");
        check_value(`XLEN'(jump_o), `XLEN'(jump), "jump_o");
        check_value(jump_target_o, target, "jump_target_o");
        check_value(mem_address_o, addr, "mem_address_o");
        check_value(`XLEN'(mem_read_enable_o), `XLEN'(rd_en), "mem_read_enable_o");
        check_value(`XLEN'(mem_write_enable_o), `XLEN'(wr_en), "mem_write_enable_o");
        if (wr_en != '0) begin
            check_value(mem_write_data_o, wr_data, "mem_write_data_o");
        end
        if (!reset_n) begin
            exp_result = '0;
            exp_rd     = '0;
            exp_we     = 1'b0;
            exp_op     = exec_pkg::NOP;
        end else if (!stall) begin
            exp_result = result;
            exp_rd     = rd;
            exp_we     = we;
            exp_op     = operation;
        end
        checks_done++;
    endtask

    // Sample just before the next rising edge
    initial begin : output_check
        forever begin
            @(posedge clk);
            #35;
            compare_outputs();
        end
    end

    ////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Random operation in [first, first + count) with random operands and stall
    task automatic randomize_inputs(input exec_pkg::op_e first, input int count);
        logic [31:0] bits;
        next_cycle();
        take_bits(5, bits);
        operation = exec_pkg::op_e'(5'(int'(first) + int'(bits) % count));
        take_bits(32, bits);
        pc = {bits[31:1], 1'b0};
        take_bits(32, rs1_data);
        take_bits(32, rs2_data);
        take_bits(32, jump_imm_target);
        // Immediate or rs2 as decode would pick
        take_bits(1, bits);
        if (bits[0]) begin
            second_operand = rs2_data;
        end else begin
            take_bits(32, second_operand);
        end
        take_bits(9, bits);
        rd         = (bits[7:5] == 3'd0) ? '0 : bits[4:0];
        compressed = bits[8];
        take_bits(2, bits);
        stall = &bits[1:0];
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while (write_enable_o || mem_read_enable_o || (mem_write_enable_o != '0) || jump_o
               || (operation_o != exec_pkg::NOP)) begin
            if (cycles == 20) begin
                $display("timeout: the stage did not settle to idle after reset");
                stop_on_failure();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic wait_for_checks(input int count);
        int target;
        int cycles;
        target = checks_done + count;
        cycles = 0;
        while (checks_done < target) begin
            if (cycles == 10) begin
                $display("timeout: the output checker stopped sampling");
                stop_on_failure();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    initial begin : stimulus
        int n;
        lfsr_state      = 32'hedd1;
        checks_done     = 0;
        exp_result      = '0;
        exp_rd          = '0;
        exp_we          = 1'b0;
        exp_op          = exec_pkg::NOP;
        reset_n         = 1'b0;
        stall           = 1'b0;
        operation       = exec_pkg::NOP;
        pc              = '0;
        rs1_data        = '0;
        rs2_data        = '0;
        second_operand  = '0;
        jump_imm_target = '0;
        rd              = '0;
        compressed      = 1'b0;
        repeat (10) @(posedge clk);
        #2;
        reset_n = 1'b1;
        wait_for_idle();

        // ADD through AUIPC
        repeat (300) randomize_inputs(exec_pkg::ADD, 12);

        // Every jal/jalr and compressed pairing first
        for (n = 0; n < 4; n++) begin
            randomize_inputs(exec_pkg::JAL, 2);
            operation  = n[0] ? exec_pkg::JALR : exec_pkg::JAL;
            compressed = n[1];
        end
        repeat (40) randomize_inputs(exec_pkg::JAL, 2);

        // Branches compare rs1 with rs2
        // Every fourth one runs on equal operands
        for (n = 0; n < 120; n++) begin
            randomize_inputs(exec_pkg::BEQ, 6);
            if (n % 4 == 0) begin
                rs2_data = rs1_data;
            end
            second_operand = rs2_data;
        end

        // Loads and stores
        repeat (200) randomize_inputs(exec_pkg::LB, 8);

        // Long stall with inputs still moving
        repeat (6) begin
            randomize_inputs(exec_pkg::ADD, 12);
            stall = 1'b1;
        end

        // Everything mixed with bubbles included
        repeat (200) randomize_inputs(exec_pkg::NOP, 29);

        next_cycle();
        operation = exec_pkg::NOP;
        stall     = 1'b0;
        wait_for_checks(3);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* design/exec_stage.sv */
// Execute stage of the RV32I core
// Memory and jump outputs are combinational, writeback is one register stage
// The upstream stage holds its inputs while stall is high
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module exec_stage (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   stall,
    input  wire exec_pkg::op_e          operation_i,
    input  wire logic [`XLEN-1:0]       pc_i,
    input  wire logic [`XLEN-1:0]       rs1_data_i,
    input  wire logic [`XLEN-1:0]       rs2_data_i,
    input  wire logic [`XLEN-1:0]       second_operand_i,
    input  wire logic [`XLEN-1:0]       jump_imm_target_i,
    input  wire logic [`REG_ADDR_W-1:0] rd_i,
    input  wire logic                   compressed_i,
    output logic      [`XLEN-1:0]       mem_address_o,
    output logic                        mem_read_enable_o,
    output logic      [`BE_W-1:0]       mem_write_enable_o,
    output logic      [`XLEN-1:0]       mem_write_data_o,
    output logic                        jump_o,
    output logic      [`XLEN-1:0]       jump_target_o,
    output logic      [`XLEN-1:0]       result_o,
    output logic      [`XLEN-1:0]       result_fwd_o,
    output logic      [`REG_ADDR_W-1:0] rd_o,
    output logic                        write_enable_o,
    output logic                        write_enable_fwd_o,
    output exec_pkg::op_e               operation_o
);

    logic [`XLEN-1:0] sum_result;
    logic [`XLEN-1:0] alu_result;
    logic             equal;
    logic             less_than;
    logic             less_than_unsigned;
    logic             greater_equal;
    logic             greater_equal_unsigned;

    alu alu_i (
        .operation_i              (operation_i),
        .pc_i                     (pc_i),
        .rs1_data_i               (rs1_data_i),
        .second_operand_i         (second_operand_i),
        .jump_imm_target_i        (jump_imm_target_i),
        .compressed_i             (compressed_i),
        .sum_result_o             (sum_result),
        .alu_result_o             (alu_result),
        .equal_o                  (equal),
        .less_than_o              (less_than),
        .less_than_unsigned_o     (less_than_unsigned),
        .greater_equal_o          (greater_equal),
        .greater_equal_unsigned_o (greater_equal_unsigned)
    );

    branch_unit branch_unit_i (
        .operation_i              (operation_i),
        .equal_i                  (equal),
        .less_than_i              (less_than),
        .less_than_unsigned_i     (less_than_unsigned),
        .greater_equal_i          (greater_equal),
        .greater_equal_unsigned_i (greater_equal_unsigned),
        .sum_result_i             (sum_result),
        .jump_imm_target_i        (jump_imm_target_i),
        .jump_o                   (jump_o),
        .jump_target_o            (jump_target_o)
    );

    mem_request mem_request_i (
        .operation_i        (operation_i),
        .sum_result_i       (sum_result),
        .rs2_data_i         (rs2_data_i),
        .mem_address_o      (mem_address_o),
        .mem_read_enable_o  (mem_read_enable_o),
        .mem_write_enable_o (mem_write_enable_o),
        .mem_write_data_o   (mem_write_data_o)
    );

    writeback_stage writeback_stage_i (
        .clk                (clk),
        .reset_n            (reset_n),
        .stall              (stall),
        .operation_i        (operation_i),
        .alu_result_i       (alu_result),
        .rd_i               (rd_i),
        .result_o           (result_o),
        .result_fwd_o       (result_fwd_o),
        .rd_o               (rd_o),
        .write_enable_o     (write_enable_o),
        .write_enable_fwd_o (write_enable_fwd_o),
        .operation_o        (operation_o)
    );

endmodule

`default_nettype wire

/* design/writeback_stage.sv */
// Output registers of the execute stage with forwarding copies
// Registers hold while stall is high, forwarding keeps following inputs
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module writeback_stage (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   stall,
    input  wire exec_pkg::op_e          operation_i,
    input  wire logic [`XLEN-1:0]       alu_result_i,
    input  wire logic [`REG_ADDR_W-1:0] rd_i,
    output logic      [`XLEN-1:0]       result_o,
    output logic      [`XLEN-1:0]       result_fwd_o,
    output logic      [`REG_ADDR_W-1:0] rd_o,
    output logic                        write_enable_o,
    output logic                        write_enable_fwd_o,
    output exec_pkg::op_e               operation_o
);

    logic write_enable;

    // Nothing to write for bubbles, stores, branches or x0
    always_comb begin
        unique case (operation_i)
            exec_pkg::NOP,
            exec_pkg::SB, exec_pkg::SH, exec_pkg::SW,
            exec_pkg::BEQ, exec_pkg::BNE,
            exec_pkg::BLT, exec_pkg::BLTU,
            exec_pkg::BGE, exec_pkg::BGEU: write_enable = 1'b0;
            default:                       write_enable = rd_i != '0;
        endcase
    end

    ////////////////////////////////////////////////
    // Stage registers
    ////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            operation_o    <= exec_pkg::NOP;
            result_o       <= '0;
            rd_o           <= '0;
            write_enable_o <= 1'b0;
        end else if (!stall) begin
            operation_o    <= operation_i;
            result_o       <= alu_result_i;
            rd_o           <= rd_i;
            write_enable_o <= write_enable;
        end
    end

    // Same-cycle copies for the decode forwarding path
    assign result_fwd_o       = alu_result_i;
    assign write_enable_fwd_o = write_enable;

endmodule

`default_nettype wire

/* design/mem_request.sv */
// Data memory request for loads and stores, purely combinational
// Address is word aligned, lane selection comes from the byte offset
// Misaligned halfwords and words are not detected
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module mem_request (
    input  wire exec_pkg::op_e     operation_i,
    input  wire logic [`XLEN-1:0]  sum_result_i,
    input  wire logic [`XLEN-1:0]  rs2_data_i,
    output logic      [`XLEN-1:0]  mem_address_o,
    output logic                   mem_read_enable_o,
    output logic      [`BE_W-1:0]  mem_write_enable_o,
    output logic      [`XLEN-1:0]  mem_write_data_o
);

    assign mem_address_o = {sum_result_i[`XLEN-1:2], 2'b00};

    assign mem_read_enable_o = operation_i inside {
        exec_pkg::LB, exec_pkg::LBU, exec_pkg::LH, exec_pkg::LHU, exec_pkg::LW
    };

    ////////////////////////////////////////////////
    // Byte lanes
    ////////////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            // One lane picked by the byte offset
            exec_pkg::SB: mem_write_enable_o = `BE_W'(1) << sum_result_i[1:0];
            exec_pkg::SH: mem_write_enable_o = sum_result_i[1] ? 4'b1100 : 4'b0011;
            exec_pkg::SW: mem_write_enable_o = 4'b1111;
            default:      mem_write_enable_o = '0;
        endcase
    end

    // Data replicated so every lane carries the store value
    always_comb begin
        unique case (operation_i)
            exec_pkg::SB: mem_write_data_o = {4{rs2_data_i[7:0]}};
            exec_pkg::SH: mem_write_data_o = {2{rs2_data_i[15:0]}};
            default:      mem_write_data_o = rs2_data_i;
        endcase
    end

endmodule

`default_nettype wire

/* design/branch_unit.sv */
// Branch decision and jump target, purely combinational
// No prediction, a taken branch or jump always raises jump_o
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module branch_unit (
    input  wire exec_pkg::op_e     operation_i,
    input  wire logic              equal_i,
    input  wire logic              less_than_i,
    input  wire logic              less_than_unsigned_i,
    input  wire logic              greater_equal_i,
    input  wire logic              greater_equal_unsigned_i,
    input  wire logic [`XLEN-1:0]  sum_result_i,
    input  wire logic [`XLEN-1:0]  jump_imm_target_i,
    output logic                   jump_o,
    output logic      [`XLEN-1:0]  jump_target_o
);

    // Condition per branch type
    always_comb begin
        unique case (operation_i)
            exec_pkg::BEQ:  jump_o = equal_i;
            exec_pkg::BNE:  jump_o = !equal_i;
            exec_pkg::BLT:  jump_o = less_than_i;
            exec_pkg::BLTU: jump_o = less_than_unsigned_i;
            exec_pkg::BGE:  jump_o = greater_equal_i;
            exec_pkg::BGEU: jump_o = greater_equal_unsigned_i;
            exec_pkg::JAL,
            exec_pkg::JALR: jump_o = 1'b1;
            default:        jump_o = 1'b0;
        endcase
    end

    // jalr target is register based, LSB forced low
    always_comb begin
        if (operation_i == exec_pkg::JALR) begin
            jump_target_o = {sum_result_i[`XLEN-1:1], 1'b0};
        end else begin
            jump_target_o = jump_imm_target_i;
        end
    end

endmodule

`default_nettype wire

/* design/alu.sv */
// Integer ALU of the execute stage, purely combinational
// Shift amounts use only the low 5 bits of the second operand
// auipc relies on jump_imm_target_i holding pc plus the immediate
`timescale 1ns/1ps
`default_nettype none

`include "exec_macros.svh"

module alu (
    input  wire exec_pkg::op_e     operation_i,
    input  wire logic [`XLEN-1:0]  pc_i,
    input  wire logic [`XLEN-1:0]  rs1_data_i,
    input  wire logic [`XLEN-1:0]  second_operand_i,
    input  wire logic [`XLEN-1:0]  jump_imm_target_i,
    input  wire logic              compressed_i,
    output logic      [`XLEN-1:0]  sum_result_o,
    output logic      [`XLEN-1:0]  alu_result_o,
    output logic                   equal_o,
    output logic                   less_than_o,
    output logic                   less_than_unsigned_o,
    output logic                   greater_equal_o,
    output logic                   greater_equal_unsigned_o
);

    logic [`XLEN-1:0] aux_a;
    logic [`XLEN-1:0] aux_b;
    logic [`XLEN-1:0] aux_result;
    logic             is_jump;

    ////////////////////////////////////////////////
    // Adders
    ////////////////////////////////////////////////

    // Primary adder also feeds memory address and jalr target
    assign sum_result_o = rs1_data_i + second_operand_i;

    assign is_jump = (operation_i == exec_pkg::JAL) || (operation_i == exec_pkg::JALR);

    // Second adder, link value for jumps or subtraction otherwise
    always_comb begin
        if (is_jump) begin
            aux_a = pc_i;
            aux_b = compressed_i ? `XLEN'(`LINK_STEP_COMPRESSED) : `XLEN'(`LINK_STEP_FULL);
        end else begin
            aux_a = rs1_data_i;
            aux_b = -second_operand_i;
        end
    end

    assign aux_result = aux_a + aux_b;

    ////////////////////////////////////////////////
    // Compare flags
    ////////////////////////////////////////////////

    assign equal_o                  = rs1_data_i == second_operand_i;
    assign less_than_o              = $signed(rs1_data_i) < $signed(second_operand_i);
    assign less_than_unsigned_o     = rs1_data_i < second_operand_i;
    assign greater_equal_o          = !less_than_o;
    assign greater_equal_unsigned_o = !less_than_unsigned_o;

    ////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////

    always_comb begin
        unique case (operation_i)
            exec_pkg::JAL,
            exec_pkg::JALR,
            exec_pkg::SUB:    alu_result_o = aux_result;
            exec_pkg::AND_OP: alu_result_o = rs1_data_i & second_operand_i;
            exec_pkg::OR_OP:  alu_result_o = rs1_data_i | second_operand_i;
            exec_pkg::XOR_OP: alu_result_o = rs1_data_i ^ second_operand_i;
            exec_pkg::SLL:    alu_result_o = rs1_data_i << second_operand_i[4:0];
            exec_pkg::SRL:    alu_result_o = rs1_data_i >> second_operand_i[4:0];
            exec_pkg::SRA:    alu_result_o = $signed(rs1_data_i) >>> second_operand_i[4:0];
            exec_pkg::SLT:    alu_result_o = {{(`XLEN-1){1'b0}}, less_than_o};
            exec_pkg::SLTU:   alu_result_o = {{(`XLEN-1){1'b0}}, less_than_unsigned_o};
            // Decode already placed the shifted immediate here
            exec_pkg::LUI:    alu_result_o = second_operand_i;
            exec_pkg::AUIPC:  alu_result_o = jump_imm_target_i;
            // ADD, loads, stores and branches
            default:          alu_result_o = sum_result_o;
        endcase
    end

endmodule

`default_nettype wire

/* design/exec_pkg.sv */
// Decoded operations seen by the execute stage
// Only RV32I base operations are present, NOP is the bubble
`default_nettype none

package exec_pkg;

    ////////////////////////////////////////////////
    // Operation encoding
    ////////////////////////////////////////////////

    typedef enum logic [4:0] {
        // Bubble, writes nothing and never jumps
        NOP    = 5'd0,
        // Register and immediate arithmetic
        ADD,
        SUB,
        AND_OP,
        OR_OP,
        XOR_OP,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Upper immediate forms
        LUI,
        AUIPC,
        // Unconditional jumps with link
        JAL,
        JALR,
        // Conditional branches
        BEQ,
        BNE,
        BLT,
        BLTU,
        BGE,
        BGEU,
        // Loads
        LB,
        LBU,
        LH,
        LHU,
        LW,
        // Stores
        SB,
        SH,
        SW
    } op_e;

endpackage

`default_nettype wire

/* design/exec_macros.svh */
// Widths and constants shared by the execute stage RTL
// BE_W is written as a literal and must be kept at XLEN/8 by hand
// Only RV32 is covered, so XLEN other than 32 is not supported
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Data and address width
`define XLEN 32

// Register index width, 32 architectural registers
`define REG_ADDR_W 5

// One write enable per byte lane
`define BE_W 4

// Return address increments for jal and jalr
`define LINK_STEP_FULL 4

// Used when the jump came from a 16-bit encoding
`define LINK_STEP_COMPRESSED 2

`endif
